/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ex_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test: failure reported"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "test: run ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+hw
hw/ex_op_pkg.sv
hw/ex_bus_pkg.sv
hw/ex_issue_latch.sv
hw/ex_forward.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_mem_reg.sv
hw/ex_stage_top.sv
testbench/tb_ex_stage.sv

/* hw/ex_alu.sv */
// no multiply or divide; compare flags use the full 64-bit operands even for word ops
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module ex_alu
  import ex_op_pkg::*;
  import ex_bus_pkg::*;
(
  input  wire id_to_ex_t           bus,
  input  wire logic [`EX_XLEN-1:0] rs1_val,
  input  wire logic [`EX_XLEN-1:0] rs2_val,
  output logic [`EX_XLEN-1:0]      result,
  output logic                     cmp_eq,
  output logic                     cmp_lt,
  output logic                     cmp_ltu
);

  logic [`EX_XLEN-1:0] a, b;
  logic [`EX_XLEN-1:0] res_d;
  logic [31:0]         res_w;

  assign a = bus.use_rs1 ? rs1_val : bus.op1_imm;
  assign b = bus.use_rs2 ? rs2_val : bus.op2_imm;

  // doubleword path, 6-bit shift amount
  always_comb begin
    case (bus.alu_op)
      ALU_ADD:    res_d = a + b;
      ALU_SUB:    res_d = a - b;
      ALU_AND:    res_d = a & b;
      ALU_OR:     res_d = a | b;
      ALU_XOR:    res_d = a ^ b;
      ALU_SLL:    res_d = a << b[5:0];
      ALU_SRL:    res_d = a >> b[5:0];
      ALU_SRA:    res_d = $signed(a) >>> b[5:0];
      ALU_SLT:    res_d = {63'b0, $signed(a) < $signed(b)};
      ALU_SLTU:   res_d = {63'b0, a < b};
      ALU_PASS_B: res_d = b;
      default:    res_d = '0;
    endcase
  end

  // word path on the low halves, 5-bit shift amount
  always_comb begin
    case (bus.alu_op)
      ALU_ADD:    res_w = a[31:0] + b[31:0];
      ALU_SUB:    res_w = a[31:0] - b[31:0];
      ALU_AND:    res_w = a[31:0] & b[31:0];
      ALU_OR:     res_w = a[31:0] | b[31:0];
      ALU_XOR:    res_w = a[31:0] ^ b[31:0];
      ALU_SLL:    res_w = a[31:0] << b[4:0];
      ALU_SRL:    res_w = a[31:0] >> b[4:0];
      ALU_SRA:    res_w = $signed(a[31:0]) >>> b[4:0];
      ALU_SLT:    res_w = {31'b0, $signed(a[31:0]) < $signed(b[31:0])};
      ALU_SLTU:   res_w = {31'b0, a[31:0] < b[31:0]};
      ALU_PASS_B: res_w = b[31:0];
      default:    res_w = '0;
    endcase
  end

  // word results are sign-extended to 64 bits
  assign result = bus.is_word ? {{32{res_w[31]}}, res_w} : res_d;

  // flags for branch resolution
  assign cmp_eq  = (a == b);
  assign cmp_lt  = ($signed(a) < $signed(b));
  assign cmp_ltu = (a < b);

endmodule

`default_nettype wire

/* hw/ex_branch.sv */
// resolves in the same cycle; jalr target ignores misalignment above bit 0
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module ex_branch
  import ex_op_pkg::*;
  import ex_bus_pkg::*;
(
  input  wire logic                valid,
  input  wire id_to_ex_t           bus,
  input  wire logic [`EX_XLEN-1:0] rs1_val,
  input  wire logic                cmp_eq,
  input  wire logic                cmp_lt,
  input  wire logic                cmp_ltu,
  input  wire logic                hazard,
  output bj_ctrl_t                 bj_ctrl
);

  logic                cond;
  logic [`EX_XLEN-1:0] jalr_sum;

  always_comb begin
    case (bus.bj_op)
      BJ_BEQ:  cond = cmp_eq;
      BJ_BNE:  cond = !cmp_eq;
      BJ_BLT:  cond = cmp_lt;
      BJ_BGE:  cond = !cmp_lt;
      BJ_BLTU: cond = cmp_ltu;
      BJ_BGEU: cond = !cmp_ltu;
      BJ_JAL,
      BJ_JALR: cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum = rs1_val + bus.jmp_imm;

  // operands are only final once no load is pending
  assign bj_ctrl.bj_valid = valid && (bus.bj_op != BJ_NONE) && !hazard;
  assign bj_ctrl.taken    = bj_ctrl.bj_valid && cond;
  assign bj_ctrl.target   = (bus.bj_op == BJ_JALR) ? {jalr_sum[`EX_XLEN-1:1], 1'b0}
                                                   : bus.pc + bus.jmp_imm;

endmodule

`default_nettype wire

/* hw/ex_bus_pkg.sv */
// bundle layouts shared with decode, memory and fetch; no CSR or exception fields
`default_nettype none

package ex_bus_pkg;

  `include "ex_params.svh"
  import ex_op_pkg::*;

  // decode to execute bundle
  typedef struct packed {
    logic [`EX_XLEN-1:0]    pc;
    logic [`EX_RADDR_W-1:0] rs1_addr;
    logic [`EX_RADDR_W-1:0] rs2_addr;
    logic                   use_rs1;
    logic                   use_rs2;
    logic [`EX_XLEN-1:0]    op1_imm;
    logic [`EX_XLEN-1:0]    op2_imm;
    logic                   is_word;
    alu_op_e                alu_op;
    bj_op_e                 bj_op;
    logic [`EX_XLEN-1:0]    jmp_imm;
    logic                   is_load;
    logic                   is_store;
    logic                   reg_we;
    logic [`EX_RADDR_W-1:0] rd_addr;
  } id_to_ex_t;

  // forwarding tap from a later stage
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [`EX_RADDR_W-1:0] rd_addr;
    logic [`EX_XLEN-1:0]    data;
    // load still in flight, data not usable yet
    logic                   is_load;
  } fwd_tap_t;

  // redirect request toward fetch
  typedef struct packed {
    logic                bj_valid;
    logic                taken;
    logic [`EX_XLEN-1:0] target;
  } bj_ctrl_t;

  // execute to memory bundle
  typedef struct packed {
    logic [`EX_XLEN-1:0]    pc;
    logic [`EX_XLEN-1:0]    alu_result;
    logic [`EX_XLEN-1:0]    store_data;
    logic                   is_load;
    logic                   is_store;
    logic                   reg_we;
    logic [`EX_RADDR_W-1:0] rd_addr;
  } ex_to_mem_t;

endpackage

`default_nettype wire

/* hw/ex_forward.sv */
// taps must carry rd_addr 0 as never-forwarded; only the memory tap can raise a hazard
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module ex_forward
  import ex_bus_pkg::*;
(
  input  wire logic                valid,
  input  wire id_to_ex_t           bus,
  input  wire logic [`EX_XLEN-1:0] rs1_data,
  input  wire logic [`EX_XLEN-1:0] rs2_data,
  input  wire fwd_tap_t            mem_tap,
  input  wire fwd_tap_t            wb_tap,
  output logic [`EX_XLEN-1:0]      rs1_val,
  output logic [`EX_XLEN-1:0]      rs2_val,
  output logic                     hazard
);

  logic mem_hit1, mem_hit2;
  logic wb_hit1, wb_hit2;

  // x0 never matches a tap
  assign mem_hit1 = mem_tap.valid && mem_tap.we && (mem_tap.rd_addr != '0)
                    && (mem_tap.rd_addr == bus.rs1_addr);
  assign mem_hit2 = mem_tap.valid && mem_tap.we && (mem_tap.rd_addr != '0)
                    && (mem_tap.rd_addr == bus.rs2_addr);
  assign wb_hit1  = wb_tap.valid && wb_tap.we && (wb_tap.rd_addr != '0)
                    && (wb_tap.rd_addr == bus.rs1_addr);
  assign wb_hit2  = wb_tap.valid && wb_tap.we && (wb_tap.rd_addr != '0)
                    && (wb_tap.rd_addr == bus.rs2_addr);

  // memory tap before writeback tap before register file
  always_comb begin
    if (bus.rs1_addr == '0) begin
      rs1_val = '0;
    end else if (mem_hit1) begin
      rs1_val = mem_tap.data;
    end else if (wb_hit1) begin
      rs1_val = wb_tap.data;
    end else begin
      rs1_val = rs1_data;
    end

    if (bus.rs2_addr == '0) begin
      rs2_val = '0;
    end else if (mem_hit2) begin
      rs2_val = mem_tap.data;
    end else if (wb_hit2) begin
      rs2_val = wb_tap.data;
    end else begin
      rs2_val = rs2_data;
    end
  end

  // load result not back yet
  assign hazard = valid && mem_tap.is_load
                  && ((bus.use_rs1 && mem_hit1) || (bus.use_rs2 && mem_hit2));

endmodule

`default_nettype wire

/* hw/ex_issue_latch.sv */
// holds one decoded instruction; there is no flush input so a squashed instruction must drain
`timescale 1ns/1ps
`default_nettype none

module ex_issue_latch
  import ex_bus_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      in_valid,
  input  wire id_to_ex_t in_bus,
  input  wire logic      ready_go,
  input  wire logic      out_allowin,
  output logic           allowin,
  output logic           valid,
  output id_to_ex_t      bus
);

  // empty, or the held instruction leaves on this edge
  assign allowin = !valid || (ready_go && out_allowin);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (allowin) begin
      valid <= in_valid;
    end
  end

  // payload follows the transfer
  always_ff @(posedge clk) begin
    if (in_valid && allowin) begin
      bus <= in_bus;
    end
  end

  // a stalled instruction keeps its slot and its fields
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    valid && !(ready_go && out_allowin) |=> valid && $stable(bus))
    else $error("issue latch changed while stalled");

  // decode holds a pending instruction until it is taken
  a_in_hold: assert property (@(posedge clk) disable iff (rst)
    in_valid && !allowin |=> in_valid && $stable(in_bus))
    else $error("decode bundle changed before it was taken");

endmodule

`default_nettype wire

/* hw/ex_mem_reg.sv */
// single-entry output register; mem_allowin low holds the entry in place
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg
  import ex_bus_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       in_valid,
  input  wire ex_to_mem_t in_bus,
  input  wire logic       mem_allowin,
  output logic            allowin,
  output logic            out_valid,
  output ex_to_mem_t      out_bus
);

  // room when empty or the entry drains this edge
  assign allowin = !out_valid || mem_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (allowin) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && allowin) begin
      out_bus <= in_bus;
    end
  end

  // memory stage sees a steady bundle until it takes it
  a_backpressure_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !mem_allowin |=> out_valid && $stable(out_bus))
    else $error("execute output changed under back-pressure");

endmodule

`default_nettype wire

/* hw/ex_op_pkg.sv */
// opcode encodings must match what the decode stage emits; value 0 is add / no branch
`default_nettype none

package ex_op_pkg;

  `include "ex_params.svh"

  // ALU operations, word form chosen by the is_word flag
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_SLT    = 4'd8,
    ALU_SLTU   = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // branch and jump kinds
  typedef enum logic [`EX_BJ_OP_W-1:0] {
    BJ_NONE = 4'd0,
    BJ_BEQ  = 4'd1,
    BJ_BNE  = 4'd2,
    BJ_BLT  = 4'd3,
    BJ_BGE  = 4'd4,
    BJ_BLTU = 4'd5,
    BJ_BGEU = 4'd6,
    BJ_JAL  = 4'd7,
    BJ_JALR = 4'd8
  } bj_op_e;

endpackage

`default_nettype wire

/* hw/ex_params.svh */
// widths are fixed by RV64 and are not meant to be overridden per instance
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// register file data and address widths
`define EX_XLEN 64
`define EX_RADDR_W 5

// opcode widths
`define EX_ALU_OP_W 4
// nine branch and jump kinds need four bits
`define EX_BJ_OP_W 4

`endif

/* hw/ex_stage_top.sv */
// register file read is combinational on rs1_addr/rs2_addr; no flush, CSR or exceptions
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module ex_stage_top
  import ex_op_pkg::*;
  import ex_bus_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   id_to_ex_valid,
  input  wire id_to_ex_t              id_to_ex,
  output logic                        ex_allowin,
  output logic [`EX_RADDR_W-1:0]      rs1_addr,
  output logic [`EX_RADDR_W-1:0]      rs2_addr,
  input  wire logic [`EX_XLEN-1:0]    rs1_data,
  input  wire logic [`EX_XLEN-1:0]    rs2_data,
  input  wire fwd_tap_t               mem_tap,
  input  wire fwd_tap_t               wb_tap,
  output bj_ctrl_t                    bj_ctrl,
  input  wire logic                   if_bj_ready,
  output logic                        ex_to_mem_valid,
  output ex_to_mem_t                  ex_to_mem,
  input  wire logic                   mem_allowin
);

  logic                ex_valid, ready_go, mem_reg_allowin, hazard;
  logic                cmp_eq, cmp_lt, cmp_ltu, is_jump;
  logic [`EX_XLEN-1:0] rs1_val, rs2_val, alu_result;
  id_to_ex_t           ex_bus;
  ex_to_mem_t          ex_result;

  ex_issue_latch u_latch (
    .clk(clk), .rst(rst),
    .in_valid(id_to_ex_valid), .in_bus(id_to_ex),
    .ready_go(ready_go), .out_allowin(mem_reg_allowin),
    .allowin(ex_allowin), .valid(ex_valid), .bus(ex_bus)
  );

  assign rs1_addr = ex_bus.rs1_addr;
  assign rs2_addr = ex_bus.rs2_addr;

  ex_forward u_forward (
    .valid(ex_valid), .bus(ex_bus),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .mem_tap(mem_tap), .wb_tap(wb_tap),
    .rs1_val(rs1_val), .rs2_val(rs2_val), .hazard(hazard)
  );

  ex_alu u_alu (
    .bus(ex_bus), .rs1_val(rs1_val), .rs2_val(rs2_val),
    .result(alu_result), .cmp_eq(cmp_eq), .cmp_lt(cmp_lt), .cmp_ltu(cmp_ltu)
  );

  ex_branch u_branch (
    .valid(ex_valid), .bus(ex_bus), .rs1_val(rs1_val),
    .cmp_eq(cmp_eq), .cmp_lt(cmp_lt), .cmp_ltu(cmp_ltu),
    .hazard(hazard), .bj_ctrl(bj_ctrl)
  );

  // a branch leaves only once fetch has taken the redirect
  assign ready_go = !hazard && ((ex_bus.bj_op == BJ_NONE) || (bj_ctrl.bj_valid && if_bj_ready));

  // jumps write back the link address
  assign is_jump = (ex_bus.bj_op == BJ_JAL) || (ex_bus.bj_op == BJ_JALR);

  assign ex_result.pc         = ex_bus.pc;
  assign ex_result.alu_result = is_jump ? ex_bus.pc + 64'd4 : alu_result;
  assign ex_result.store_data = rs2_val;
  assign ex_result.is_load    = ex_bus.is_load;
  assign ex_result.is_store   = ex_bus.is_store;
  assign ex_result.reg_we     = ex_bus.reg_we;
  assign ex_result.rd_addr    = ex_bus.rd_addr;

  ex_mem_reg u_mem_reg (
    .clk(clk), .rst(rst),
    .in_valid(ex_valid && ready_go), .in_bus(ex_result),
    .mem_allowin(mem_allowin), .allowin(mem_reg_allowin),
    .out_valid(ex_to_mem_valid), .out_bus(ex_to_mem)
  );

endmodule

`default_nettype wire

/* testbench/tb_ex_stage.sv */
// register file and taps are modeled here; taps stay fixed while an instruction is in flight
`timescale 1ns/1ps
`default_nettype none
`include "ex_params.svh"

module tb_ex_stage
  import ex_op_pkg::*;
  import ex_bus_pkg::*;
();

  localparam int TIMEOUT = 100;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   id_to_ex_valid;
  id_to_ex_t              id_to_ex;
  logic                   ex_allowin;
  logic [`EX_RADDR_W-1:0] rs1_addr;
  logic [`EX_RADDR_W-1:0] rs2_addr;
  logic [`EX_XLEN-1:0]    rs1_data;
  logic [`EX_XLEN-1:0]    rs2_data;
  fwd_tap_t               mem_tap;
  fwd_tap_t               wb_tap;
  bj_ctrl_t               bj_ctrl;
  logic                   if_bj_ready;
  logic                   ex_to_mem_valid;
  ex_to_mem_t             ex_to_mem;
  logic                   mem_allowin;

  logic [`EX_XLEN-1:0] regfile [32];
  ex_to_mem_t          exp_q [$];
  bj_ctrl_t            bj_q [$];
  int                  out_cyc_q [$];
  int                  seed = 42;
  int                  cyc = 0;
  int                  last_acc_cyc = 0;
  int                  err_val = 0;
  int                  err_other = 0;

  ex_stage_top UUT (
    .clk(clk), .rst(rst),
    .id_to_ex_valid(id_to_ex_valid), .id_to_ex(id_to_ex), .ex_allowin(ex_allowin),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .mem_tap(mem_tap), .wb_tap(wb_tap), .bj_ctrl(bj_ctrl), .if_bj_ready(if_bj_ready),
    .ex_to_mem_valid(ex_to_mem_valid), .ex_to_mem(ex_to_mem), .mem_allowin(mem_allowin)
  );

  always #4 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // combinational register file read
  assign rs1_data = regfile[rs1_addr];
  assign rs2_data = regfile[rs2_addr];

  function automatic logic [63:0] rnd64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic fwd_tap_t make_tap(input logic [4:0] rd, input logic [63:0] data);
    fwd_tap_t t;
    t.valid = 1'b1;
    t.we = 1'b1;
    t.rd_addr = rd;
    t.data = data;
    t.is_load = 1'b0;
    return t;
  endfunction

  function automatic id_to_ex_t base_ins();
    id_to_ex_t ins;
    ins = '0;
    ins.pc = rnd64() & ~64'h3;
    ins.rs1_addr = 5'($random(seed));
    ins.rs2_addr = 5'($random(seed));
    ins.use_rs1 = 1'b1;
    ins.use_rs2 = 1'b1;
    ins.op1_imm = rnd64();
    ins.op2_imm = rnd64();
    ins.jmp_imm = rnd64();
    ins.is_load = 1'($random(seed));
    ins.is_store = 1'($random(seed));
    ins.reg_we = 1'b1;
    ins.rd_addr = 5'($random(seed));
    return ins;
  endfunction

  // newest producer first and x0 always reads zero
  function automatic logic [63:0] src_value(input logic [4:0] addr, input fwd_tap_t mt,
                                            input fwd_tap_t wt);
    if (addr == 5'd0) return '0;
    if (mt.valid && mt.we && mt.rd_addr == addr) return mt.data;
    if (wt.valid && wt.we && wt.rd_addr == addr) return wt.data;
    return regfile[addr];
  endfunction

  // word ops run on extended operands and the low half is sign-extended at the end
  function automatic logic [63:0] alu_model(input alu_op_e op, input logic w,
                                            input logic [63:0] a, input logic [63:0] b);
    logic [63:0] x, y, r;
    int unsigned sh;
    x = a;
    y = b;
    sh = w ? {27'd0, b[4:0]} : {26'd0, b[5:0]};
    if (w) begin
      x = (op == ALU_SRL || op == ALU_SLTU) ? {32'd0, a[31:0]} : sext32(a[31:0]);
      y = (op == ALU_SRL || op == ALU_SLTU) ? {32'd0, b[31:0]} : sext32(b[31:0]);
    end
    case (op)
      ALU_ADD:    r = x + y;
      ALU_SUB:    r = x - y;
      ALU_AND:    r = x & y;
      ALU_OR:     r = x | y;
      ALU_XOR:    r = x ^ y;
      ALU_SLL:    r = x << sh;
      ALU_SRL:    r = x >> sh;
      ALU_SRA:    r = $signed(x) >>> sh;
      ALU_SLT:    r = ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
      ALU_SLTU:   r = (x < y) ? 64'd1 : 64'd0;
      ALU_PASS_B: r = y;
      default:    r = '0;
    endcase
    return w ? sext32(r[31:0]) : r;
  endfunction

  function automatic ex_to_mem_t result_model(input id_to_ex_t ins, input fwd_tap_t mt,
                                              input fwd_tap_t wt);
    ex_to_mem_t e;
    logic [63:0] r1, r2;
    r1 = src_value(ins.rs1_addr, mt, wt);
    r2 = src_value(ins.rs2_addr, mt, wt);
    e.pc = ins.pc;
    if (ins.bj_op == BJ_JAL || ins.bj_op == BJ_JALR) begin
      e.alu_result = ins.pc + 64'd4;
    end else begin
      e.alu_result = alu_model(ins.alu_op, ins.is_word, ins.use_rs1 ? r1 : ins.op1_imm,
                               ins.use_rs2 ? r2 : ins.op2_imm);
    end
    e.store_data = r2;
    e.is_load = ins.is_load;
    e.is_store = ins.is_store;
    e.reg_we = ins.reg_we;
    e.rd_addr = ins.rd_addr;
    return e;
  endfunction

  function automatic bj_ctrl_t bj_model(input id_to_ex_t ins, input fwd_tap_t mt,
                                        input fwd_tap_t wt);
    bj_ctrl_t c;
    logic [63:0] a, b;
    a = ins.use_rs1 ? src_value(ins.rs1_addr, mt, wt) : ins.op1_imm;
    b = ins.use_rs2 ? src_value(ins.rs2_addr, mt, wt) : ins.op2_imm;
    case (ins.bj_op)
      BJ_BEQ:  c.taken = (a == b);
      BJ_BNE:  c.taken = (a != b);
      BJ_BLT:  c.taken = ($signed(a) < $signed(b));
      BJ_BGE:  c.taken = ($signed(a) >= $signed(b));
      BJ_BLTU: c.taken = (a < b);
      BJ_BGEU: c.taken = (a >= b);
      BJ_JAL,
      BJ_JALR: c.taken = 1'b1;
      default: c.taken = 1'b0;
    endcase
    c.bj_valid = 1'b1;
    if (ins.bj_op == BJ_JALR) begin
      c.target = (src_value(ins.rs1_addr, mt, wt) + ins.jmp_imm) & ~64'd1;
    end else begin
      c.target = ins.pc + ins.jmp_imm;
    end
    return c;
  endfunction

  task automatic mem_check(input ex_to_mem_t got, input ex_to_mem_t exp, input string name);
    if (got !== exp) begin
      err_val++;
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic bj_check(input bj_ctrl_t got, input bj_ctrl_t exp, input string name);
    if (got !== exp) begin
      err_val++;
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic bit_check(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      err_val++;
      $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic addr_check(input logic [`EX_RADDR_W-1:0] got,
                            input logic [`EX_RADDR_W-1:0] exp, input string name);
    if (got !== exp) begin
      err_val++;
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // output side sampled mid-cycle where everything is settled
  always @(negedge clk) begin
    if (!rst) begin
      if (ex_to_mem_valid && mem_allowin) begin
        out_cyc_q.push_back(cyc);
        if (exp_q.size() == 0) begin
          err_other++;
          $display("ERROR at %0t: result on ex_to_mem that no test expected", $time);
        end else begin
          mem_check(ex_to_mem, exp_q.pop_front(), "ex_to_mem");
        end
      end
      if (bj_ctrl.bj_valid && if_bj_ready) begin
        if (bj_q.size() == 0) begin
          err_other++;
          $display("ERROR at %0t: redirect on bj_ctrl that no test expected", $time);
        end else begin
          bj_check(bj_ctrl, bj_q.pop_front(), "bj_ctrl");
        end
      end
    end
  end

  // starts and ends 1 ns after a rising edge
  task automatic issue(input id_to_ex_t ins);
    int n;
    id_to_ex_valid = 1'b1;
    id_to_ex = ins;
    n = 0;
    @(negedge clk);
    while (!ex_allowin && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!ex_allowin) begin
      err_other++;
      $display("ERROR at %0t: execute stage never accepted the instruction", $time);
    end
    @(posedge clk);
    #1;
    last_acc_cyc = cyc;
    id_to_ex_valid = 1'b0;
    // register file is read from the latched bundle
    addr_check(rs1_addr, ins.rs1_addr, "rs1_addr");
    addr_check(rs2_addr, ins.rs2_addr, "rs2_addr");
  endtask

  task automatic expect_and_issue(input id_to_ex_t ins, input fwd_tap_t mt,
                                  input fwd_tap_t wt);
    exp_q.push_back(result_model(ins, mt, wt));
    if (ins.bj_op != BJ_NONE) bj_q.push_back(bj_model(ins, mt, wt));
    issue(ins);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || bj_q.size() != 0) && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (exp_q.size() != 0 || bj_q.size() != 0) begin
      err_other++;
      $display("ERROR at %0t: %0d results and %0d redirects never arrived",
               $time, exp_q.size(), bj_q.size());
      exp_q.delete();
      bj_q.delete();
    end
  endtask

  task automatic alu_sweep();
    id_to_ex_t ins;
    for (int op = 0; op <= 10; op++) begin
      for (int w = 0; w < 2; w++) begin
        // all four immediate/register source mixes
        for (int m = 0; m < 4; m++) begin
          ins = base_ins();
          ins.alu_op = alu_op_e'(op[3:0]);
          ins.is_word = w[0];
          ins.use_rs1 = m[0];
          ins.use_rs2 = m[1];
          expect_and_issue(ins, mem_tap, wb_tap);
        end
      end
    end
    drain();
  endtask

  task automatic forwarding_cases();
    id_to_ex_t ins;
    for (int c = 0; c < 4; c++) begin
      ins = base_ins();
      ins.rs1_addr = 5'd7;
      ins.rs2_addr = 5'd9;
      mem_tap = make_tap(5'd7, rnd64());
      wb_tap = make_tap(5'd9, rnd64());
      case (c)
        1: begin
          ins.rs2_addr = 5'd7;
          wb_tap.rd_addr = 5'd7;
        end
        2: begin
          mem_tap.valid = 1'b0;
          wb_tap.rd_addr = 5'd7;
        end
        // x0 with both taps claiming it
        3: begin
          ins.rs1_addr = 5'd0;
          mem_tap.rd_addr = 5'd0;
          wb_tap.rd_addr = 5'd0;
        end
        default: ;
      endcase
      expect_and_issue(ins, mem_tap, wb_tap);
      drain();
    end
    mem_tap = '0;
    wb_tap = '0;
  endtask

  task automatic load_use_stall();
    id_to_ex_t ins;
    fwd_tap_t done_tap;
    ins = base_ins();
    ins.rs1_addr = 5'd12;
    done_tap = make_tap(5'd12, rnd64());
    mem_tap = done_tap;
    mem_tap.is_load = 1'b1;
    mem_tap.data = ~done_tap.data;
    expect_and_issue(ins, done_tap, wb_tap);
    repeat (4) begin
      @(negedge clk);
      bit_check(ex_to_mem_valid, 1'b0, "ex_to_mem_valid");
      bit_check(ex_allowin, 1'b0, "ex_allowin");
    end
    @(posedge clk);
    #1;
    // load data now available on the memory tap
    mem_tap = done_tap;
    drain();
    mem_tap = '0;
  endtask

  task automatic branch_cases();
    id_to_ex_t ins;
    for (int op = 1; op <= 8; op++) begin
      // operand pairs (1,1), (1,-1), (-1,1)
      for (int pr = 0; pr < 3; pr++) begin
        regfile[5] = (pr == 2) ? '1 : 64'd1;
        regfile[6] = (pr == 1) ? '1 : 64'd1;
        ins = base_ins();
        ins.rs1_addr = 5'd5;
        ins.rs2_addr = 5'd6;
        ins.bj_op = bj_op_e'(op[3:0]);
        if_bj_ready = 1'b0;
        expect_and_issue(ins, mem_tap, wb_tap);
        repeat (3) begin
          @(negedge clk);
          bit_check(bj_ctrl.bj_valid, 1'b1, "bj_ctrl.bj_valid");
          bit_check(ex_to_mem_valid, 1'b0, "ex_to_mem_valid");
        end
        @(posedge clk);
        #1;
        if_bj_ready = 1'b1;
        drain();
      end
    end
  endtask

  task automatic backpressure_hold();
    id_to_ex_t ins;
    mem_allowin = 1'b0;
    for (int i = 0; i < 2; i++) begin
      ins = base_ins();
      expect_and_issue(ins, mem_tap, wb_tap);
    end
    @(negedge clk);
    bit_check(ex_allowin, 1'b0, "ex_allowin");
    bit_check(ex_to_mem_valid, 1'b1, "ex_to_mem_valid");
    mem_check(ex_to_mem, exp_q[0], "ex_to_mem while held");
    repeat (3) begin
      @(negedge clk);
      mem_check(ex_to_mem, exp_q[0], "ex_to_mem while held");
      bit_check(ex_to_mem_valid, 1'b1, "ex_to_mem_valid");
      bit_check(ex_allowin, 1'b0, "ex_allowin");
    end
    @(posedge clk);
    #1;
    mem_allowin = 1'b1;
    for (int i = 0; i < 4; i++) begin
      ins = base_ins();
      expect_and_issue(ins, mem_tap, wb_tap);
    end
    drain();
  endtask

  task automatic streaming_rate();
    id_to_ex_t ins;
    int first_acc;
    first_acc = 0;
    out_cyc_q.delete();
    for (int i = 0; i < 8; i++) begin
      ins = base_ins();
      expect_and_issue(ins, mem_tap, wb_tap);
      if (i == 0) first_acc = last_acc_cyc;
    end
    drain();
    if (out_cyc_q.size() != 8) begin
      err_other++;
      $display("ERROR at %0t: streaming gave %0d results instead of 8", $time, out_cyc_q.size());
    end else begin
      if (out_cyc_q[0] != first_acc + 1) begin
        err_other++;
        $display("ERROR at %0t: first result did not follow its acceptance by one cycle", $time);
      end
      for (int i = 1; i < 8; i++) begin
        if (out_cyc_q[i] != out_cyc_q[i-1] + 1) begin
          err_other++;
          $display("ERROR at %0t: gap in the result stream before result %0d", $time, i);
        end
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    id_to_ex_valid = 1'b0;
    id_to_ex = '0;
    mem_tap = '0;
    wb_tap = '0;
    if_bj_ready = 1'b1;
    mem_allowin = 1'b1;
    for (int i = 0; i < 32; i++) regfile[i] = rnd64();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    bit_check(ex_to_mem_valid, 1'b0, "ex_to_mem_valid");
    bit_check(bj_ctrl.bj_valid, 1'b0, "bj_ctrl.bj_valid");
    bit_check(ex_allowin, 1'b1, "ex_allowin");
    @(posedge clk);
    #1;
    alu_sweep();
    forwarding_cases();
    load_use_stall();
    branch_cases();
    backpressure_hold();
    streaming_rate();
    $display("errors: %0d wrong values, %0d other failures", err_val, err_other);
    if (err_val + err_other == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
